//--- Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing -Wno-fatal --top-module tb_npc -f npc.f -o Vtb_npc --Mdir obj_dir
	./obj_dir/Vtb_npc | awk '{ print } /Test OK/ { ok = 1 } END { exit !ok }'

clean:
	rm -rf obj_dir

//--- logic/alu.sv
`timescale 1ns/1ps

module alu (
    input  npc_ctrl_pkg::word_t   src1,
    input  npc_ctrl_pkg::word_t   src2,
    input  npc_ctrl_pkg::alu_op_e alu_op,
    output npc_ctrl_pkg::word_t   result
);

    npc_ctrl_pkg::word_t sum;
    npc_ctrl_pkg::word_t diff;

    assign sum  = src1 + src2;
    assign diff = src1 - src2;

    always_comb begin
        case (alu_op)
            npc_ctrl_pkg::alu_add:  result = sum;
            npc_ctrl_pkg::alu_sub:  result = diff;
            // unsigned compare as 0/1
            npc_ctrl_pkg::alu_sltu: result = {31'b0, (src1 < src2)};
            npc_ctrl_pkg::alu_xor:  result = src1 ^ src2;
            npc_ctrl_pkg::alu_or:   result = src1 | src2;
            // bne condition, read back by the pc logic
            npc_ctrl_pkg::alu_ne:   result = {31'b0, (src1 != src2)};
            default:                result = sum;
        endcase
    end

endmodule

//--- logic/data_mem.sv
`timescale 1ns/1ps

module data_mem #(
    parameter int DATA_WORDS = 256
) (
    input  logic                clk,
    input  logic                reset,
    input  npc_ctrl_pkg::word_t addr,
    input  npc_ctrl_pkg::word_t wdata,
    npc_ctrl_if.mem             bus,
    input  logic                write_en,
    output npc_ctrl_pkg::word_t rdata
);

    localparam int IDX_W = (DATA_WORDS > 1) ? $clog2(DATA_WORDS) : 1;

    npc_ctrl_pkg::word_t mem [DATA_WORDS];
    logic [IDX_W-1:0]    word_idx;
    logic [1:0]          lane;
    npc_ctrl_pkg::word_t rd_word;

    // word index wraps modulo depth, lane is the low address bits
    assign word_idx = IDX_W'((addr >> 2) % DATA_WORDS);
    assign lane     = addr[1:0];
    assign rd_word  = mem[word_idx];

    // load path, lbu zero-extends the addressed byte
    always_comb begin
        rdata = '0;
        if (bus.mem_read) begin
            if (bus.mem_byte) begin
                rdata = {24'b0, rd_word[lane*8 +: 8]};
            end else begin
                rdata = rd_word;
            end
        end
    end

    // store path, sb touches one lane only
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < DATA_WORDS; i++) begin
                mem[i] <= '0;
            end
        end else if (write_en) begin
            if (bus.mem_byte) begin
                mem[word_idx][lane*8 +: 8] <= wdata[7:0];
            end else begin
                mem[word_idx] <= wdata;
            end
        end
    end

    // write strobe from the top must come from a decoded store
    a_wr_is_store: assert property (@(posedge clk) disable iff (reset)
        write_en |-> bus.mem_write);

endmodule

//--- logic/inst_decode.sv
`timescale 1ns/1ps

module inst_decode (
    input  rv_isa_pkg::inst_t    inst,
    output rv_isa_pkg::reg_idx_t rs1,
    output rv_isa_pkg::reg_idx_t rs2,
    output rv_isa_pkg::reg_idx_t rd,
    npc_ctrl_if.dec              ctrl
);

    rv_isa_pkg::opcode_t opcode;
    rv_isa_pkg::funct3_t funct3;
    rv_isa_pkg::funct7_t funct7;
    npc_ctrl_pkg::word_t imm_i;
    npc_ctrl_pkg::word_t imm_s;
    npc_ctrl_pkg::word_t imm_b;
    npc_ctrl_pkg::word_t imm_u;
    npc_ctrl_pkg::word_t imm_j;

    // field slicing
    assign opcode = inst[6:0];
    assign rd     = inst[11:7];
    assign funct3 = inst[14:12];
    assign rs1    = inst[19:15];
    assign rs2    = inst[24:20];
    assign funct7 = inst[31:25];

    // immediates sign-extended from bit 31
    assign imm_i = {{20{inst[31]}}, inst[31:20]};
    assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
    assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    assign imm_u = {inst[31:12], 12'h000};
    assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

    // per-instruction recognition
    wire is_lui   = (opcode == rv_isa_pkg::op_lui);
    wire is_auipc = (opcode == rv_isa_pkg::op_auipc);
    wire is_jal   = (opcode == rv_isa_pkg::op_jal);
    wire is_jalr  = (opcode == rv_isa_pkg::op_jalr) && (funct3 == rv_isa_pkg::f3_jalr);
    wire is_addi  = (opcode == rv_isa_pkg::op_imm) && (funct3 == rv_isa_pkg::f3_addi);
    wire is_sltiu = (opcode == rv_isa_pkg::op_imm) && (funct3 == rv_isa_pkg::f3_sltiu);
    wire is_rr    = (opcode == rv_isa_pkg::op_reg) && (funct7 == rv_isa_pkg::funct7_base);
    wire is_add   = is_rr && (funct3 == rv_isa_pkg::f3_add);
    wire is_sltu  = is_rr && (funct3 == rv_isa_pkg::f3_sltu);
    wire is_xor   = is_rr && (funct3 == rv_isa_pkg::f3_xor);
    wire is_or    = is_rr && (funct3 == rv_isa_pkg::f3_or);
    wire is_sub   = (opcode == rv_isa_pkg::op_reg) && (funct7 == rv_isa_pkg::funct7_sub)
                    && (funct3 == rv_isa_pkg::f3_add);
    wire is_lw    = (opcode == rv_isa_pkg::op_load) && (funct3 == rv_isa_pkg::f3_lw);
    wire is_lbu   = (opcode == rv_isa_pkg::op_load) && (funct3 == rv_isa_pkg::f3_lbu);
    wire is_sw    = (opcode == rv_isa_pkg::op_store) && (funct3 == rv_isa_pkg::f3_sw);
    wire is_sb    = (opcode == rv_isa_pkg::op_store) && (funct3 == rv_isa_pkg::f3_sb);
    wire is_bne   = (opcode == rv_isa_pkg::op_branch) && (funct3 == rv_isa_pkg::f3_bne);

    // immediate picked by instruction class
    // unknown encodings get zero
    always_comb begin
        ctrl.imm = '0;
        if (is_addi || is_sltiu || is_jalr || is_lw || is_lbu) begin
            ctrl.imm = imm_i;
        end else if (is_sw || is_sb) begin
            ctrl.imm = imm_s;
        end else if (is_bne) begin
            ctrl.imm = imm_b;
        end else if (is_lui || is_auipc) begin
            ctrl.imm = imm_u;
        end else if (is_jal) begin
            ctrl.imm = imm_j;
        end
    end

    // alu function select
    // add also serves load/store addresses and the jalr target
    always_comb begin
        ctrl.alu_op = npc_ctrl_pkg::alu_add;
        if (is_sub) begin
            ctrl.alu_op = npc_ctrl_pkg::alu_sub;
        end else if (is_sltu || is_sltiu) begin
            ctrl.alu_op = npc_ctrl_pkg::alu_sltu;
        end else if (is_xor) begin
            ctrl.alu_op = npc_ctrl_pkg::alu_xor;
        end else if (is_or) begin
            ctrl.alu_op = npc_ctrl_pkg::alu_or;
        end else if (is_bne) begin
            ctrl.alu_op = npc_ctrl_pkg::alu_ne;
        end
    end

    // write-back source
    always_comb begin
        ctrl.wb_sel = npc_ctrl_pkg::wb_alu;
        if (is_lw || is_lbu) begin
            ctrl.wb_sel = npc_ctrl_pkg::wb_mem;
        end else if (is_jal || is_jalr) begin
            ctrl.wb_sel = npc_ctrl_pkg::wb_pc4;
        end else if (is_lui) begin
            ctrl.wb_sel = npc_ctrl_pkg::wb_imm;
        end
    end

    // operand selects
    assign ctrl.src1_is_pc  = is_auipc;
    assign ctrl.src2_is_imm = is_addi | is_sltiu | is_auipc | is_jalr
                              | is_lw | is_lbu | is_sw | is_sb;

    // write enables stay low for undefined encodings
    assign ctrl.reg_wen = is_lui | is_auipc | is_jal | is_jalr | is_addi | is_sltiu
                          | is_add | is_sub | is_xor | is_or | is_sltu | is_lw | is_lbu;
    assign ctrl.mem_read  = is_lw | is_lbu;
    assign ctrl.mem_write = is_sw | is_sb;
    assign ctrl.mem_byte  = is_lbu | is_sb;

    // next-pc controls
    assign ctrl.is_jal  = is_jal;
    assign ctrl.is_jalr = is_jalr;
    assign ctrl.is_bne  = is_bne;

    // only the exact ebreak word halts
    assign ctrl.halt = (inst == rv_isa_pkg::inst_ebreak);

endmodule

//--- logic/npc.sv
`timescale 1ns/1ps

module npc #(
    parameter int DATA_WORDS = 256
) (
    input  logic                 clk,
    input  logic                 reset,
    input  rv_isa_pkg::inst_t    inst,
    output npc_ctrl_pkg::word_t  pc,
    output npc_ctrl_pkg::word_t  alu_result,
    output logic                 wb_en,
    output rv_isa_pkg::reg_idx_t wb_addr,
    output npc_ctrl_pkg::word_t  wb_data,
    output logic                 halt
);

    rv_isa_pkg::reg_idx_t rs1;
    rv_isa_pkg::reg_idx_t rs2;
    rv_isa_pkg::reg_idx_t rd;
    npc_ctrl_pkg::word_t  rs1_data;
    npc_ctrl_pkg::word_t  rs2_data;
    npc_ctrl_pkg::word_t  alu_src1;
    npc_ctrl_pkg::word_t  alu_src2;
    npc_ctrl_pkg::word_t  mem_rdata;
    npc_ctrl_pkg::word_t  pc_plus4;
    npc_ctrl_pkg::word_t  next_pc;
    logic                 branch_taken;
    logic                 mem_wen;

    npc_ctrl_if ctrl ();

    inst_decode u_decode (
        .inst (inst),
        .rs1  (rs1),
        .rs2  (rs2),
        .rd   (rd),
        .ctrl (ctrl)
    );

    // operand muxes
    assign alu_src1 = ctrl.src1_is_pc ? pc : rs1_data;
    assign alu_src2 = ctrl.src2_is_imm ? ctrl.imm : rs2_data;

    alu u_alu (
        .src1   (alu_src1),
        .src2   (alu_src2),
        .alu_op (ctrl.alu_op),
        .result (alu_result)
    );

    // halt kills every architectural write
    assign halt    = ctrl.halt;
    assign wb_addr = rd;
    assign wb_en   = ctrl.reg_wen && !ctrl.halt && (rd != '0);
    assign mem_wen = ctrl.mem_write && !ctrl.halt;

    register_file u_regfile (
        .clk    (clk),
        .reset  (reset),
        .wen    (wb_en),
        .waddr  (rd),
        .raddr1 (rs1),
        .raddr2 (rs2),
        .wdata  (wb_data),
        .rdata1 (rs1_data),
        .rdata2 (rs2_data)
    );

    // address comes from the alu add of rs1 and imm
    data_mem #(
        .DATA_WORDS (DATA_WORDS)
    ) u_dmem (
        .clk      (clk),
        .reset    (reset),
        .addr     (alu_result),
        .wdata    (rs2_data),
        .bus      (ctrl),
        .write_en (mem_wen),
        .rdata    (mem_rdata)
    );

    // write-back value
    always_comb begin
        case (ctrl.wb_sel)
            npc_ctrl_pkg::wb_mem: wb_data = mem_rdata;
            npc_ctrl_pkg::wb_pc4: wb_data = pc_plus4;
            npc_ctrl_pkg::wb_imm: wb_data = ctrl.imm;
            default:              wb_data = alu_result;
        endcase
    end

    // next pc, jalr target is the alu sum with bit 0 cleared
    assign pc_plus4     = pc + 32'd4;
    assign branch_taken = ctrl.is_bne && (alu_result == 32'd1);
    assign next_pc = ctrl.is_jalr                  ? (alu_result & ~32'd1) :
                     (ctrl.is_jal || branch_taken) ? (pc + ctrl.imm) :
                     pc_plus4;

    // pc register, frozen while halted
    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= npc_ctrl_pkg::reset_pc;
        end else if (!ctrl.halt) begin
            pc <= next_pc;
        end
    end

    // fetch address always word aligned
    a_pc_aligned: assert property (@(posedge clk) disable iff (reset) pc[1:0] == 2'b00);

endmodule

//--- logic/npc_ctrl_if.sv
`timescale 1ns/1ps

// decoded control levels, valid in the same cycle as inst
interface npc_ctrl_if;

    npc_ctrl_pkg::alu_op_e alu_op;
    logic                  src1_is_pc;
    logic                  src2_is_imm;
    npc_ctrl_pkg::word_t   imm;
    logic                  reg_wen;
    npc_ctrl_pkg::wb_sel_e wb_sel;
    logic                  mem_read;
    logic                  mem_write;
    logic                  mem_byte;
    logic                  is_jal;
    logic                  is_jalr;
    logic                  is_bne;
    logic                  halt;

    // decoder side
    modport dec (
        output alu_op, src1_is_pc, src2_is_imm, imm, reg_wen, wb_sel,
               mem_read, mem_write, mem_byte, is_jal, is_jalr, is_bne, halt
    );

    // datapath side
    modport dp (
        input alu_op, src1_is_pc, src2_is_imm, imm, reg_wen, wb_sel,
              mem_read, mem_write, mem_byte, is_jal, is_jalr, is_bne, halt
    );

    // data memory only needs the access kind
    modport mem (input mem_read, mem_write, mem_byte);

endinterface

//--- logic/npc_ctrl_pkg.sv
package npc_ctrl_pkg;

    // data word, also used for addresses and pc
    typedef logic [31:0] word_t;

    // alu function select
    typedef enum logic [2:0] {
        alu_add  = 3'd0,
        alu_sub  = 3'd1,
        alu_sltu = 3'd2,
        alu_xor  = 3'd3,
        alu_or   = 3'd4,
        alu_ne   = 3'd5
    } alu_op_e;

    // source of the register write-back value
    typedef enum logic [1:0] {
        wb_alu = 2'd0,
        wb_mem = 2'd1,
        wb_pc4 = 2'd2,
        wb_imm = 2'd3
    } wb_sel_e;

    // first fetch address after reset
    localparam word_t reset_pc = 32'h8000_0000;

endpackage

//--- logic/register_file.sv
`timescale 1ns/1ps

module register_file (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 wen,
    input  rv_isa_pkg::reg_idx_t waddr,
    input  rv_isa_pkg::reg_idx_t raddr1,
    input  rv_isa_pkg::reg_idx_t raddr2,
    input  npc_ctrl_pkg::word_t  wdata,
    output npc_ctrl_pkg::word_t  rdata1,
    output npc_ctrl_pkg::word_t  rdata2
);

    // storage for x1..x31 only
    // x0 has none
    npc_ctrl_pkg::word_t regs [1:31];

    // write at the edge closing the instruction
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wen && (waddr != '0)) begin
            regs[waddr] <= wdata;
        end
    end

    // combinational reads with index 0 reading zero
    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

//--- logic/rv_isa_pkg.sv
package rv_isa_pkg;

    // raw instruction word and its fields
    typedef logic [31:0] inst_t;
    typedef logic [4:0]  reg_idx_t;
    typedef logic [6:0]  opcode_t;
    typedef logic [2:0]  funct3_t;
    typedef logic [6:0]  funct7_t;

    // major opcodes of the supported subset
    localparam opcode_t op_lui    = 7'b0110111;
    localparam opcode_t op_auipc  = 7'b0010111;
    localparam opcode_t op_jal    = 7'b1101111;
    localparam opcode_t op_jalr   = 7'b1100111;
    localparam opcode_t op_imm    = 7'b0010011;
    localparam opcode_t op_reg    = 7'b0110011;
    localparam opcode_t op_load   = 7'b0000011;
    localparam opcode_t op_store  = 7'b0100011;
    localparam opcode_t op_branch = 7'b1100011;

    // funct3 for register-register ops, add and sub share one
    localparam funct3_t f3_add   = 3'b000;
    localparam funct3_t f3_sltu  = 3'b011;
    localparam funct3_t f3_xor   = 3'b100;
    localparam funct3_t f3_or    = 3'b110;
    // immediate ops and jalr
    localparam funct3_t f3_addi  = 3'b000;
    localparam funct3_t f3_sltiu = 3'b011;
    localparam funct3_t f3_jalr  = 3'b000;
    // loads, stores, branches
    localparam funct3_t f3_lw    = 3'b010;
    localparam funct3_t f3_lbu   = 3'b100;
    localparam funct3_t f3_sw    = 3'b010;
    localparam funct3_t f3_sb    = 3'b000;
    localparam funct3_t f3_bne   = 3'b001;

    // funct7 picks add vs sub
    localparam funct7_t funct7_base = 7'b0000000;
    localparam funct7_t funct7_sub  = 7'b0100000;

    // the one system instruction we honour
    localparam inst_t inst_ebreak = 32'h0010_0073;

endpackage

//--- npc.f
+incdir+verif
logic/rv_isa_pkg.sv
logic/npc_ctrl_pkg.sv
logic/npc_ctrl_if.sv
logic/inst_decode.sv
logic/register_file.sv
logic/alu.sv
logic/data_mem.sv
logic/npc.sv
verif/tb_npc.sv

//--- verif/npc_ref_model.svh
`ifndef NPC_REF_MODEL_SVH
`define NPC_REF_MODEL_SVH

// architectural state of the model
npc_ctrl_pkg::word_t  m_regs [32];
npc_ctrl_pkg::word_t  m_mem [data_words];
npc_ctrl_pkg::word_t  m_pc;
bit                   m_halted;

// predictions for the cycle in flight
npc_ctrl_pkg::word_t  exp_pc;
npc_ctrl_pkg::word_t  exp_alu;
npc_ctrl_pkg::word_t  exp_wb_data;
rv_isa_pkg::reg_idx_t exp_wb_addr;
bit                   exp_wb_en;
bit                   exp_wr;
bit                   exp_alu_valid;
bit                   exp_halt;

task automatic model_reset();
    foreach (m_regs[i]) m_regs[i] = '0;
    foreach (m_mem[i]) m_mem[i] = '0;
    m_pc = npc_ctrl_pkg::reset_pc;
    m_halted = 0;
endtask

// execute one instruction at m_pc, record expectations, commit state
task automatic model_step(input rv_isa_pkg::inst_t w);
    rv_isa_pkg::opcode_t  op;
    rv_isa_pkg::funct3_t  f3;
    rv_isa_pkg::funct7_t  f7;
    rv_isa_pkg::reg_idx_t rd;
    npc_ctrl_pkg::word_t  a;
    npc_ctrl_pkg::word_t  b;
    npc_ctrl_pkg::word_t  imm_i;
    npc_ctrl_pkg::word_t  imm_s;
    npc_ctrl_pkg::word_t  imm_b;
    npc_ctrl_pkg::word_t  imm_j;
    npc_ctrl_pkg::word_t  addr;
    npc_ctrl_pkg::word_t  val;
    npc_ctrl_pkg::word_t  next;
    int                   idx;
    int                   lane;
    op = w[6:0];
    f3 = w[14:12];
    f7 = w[31:25];
    rd = w[11:7];
    a = m_regs[w[19:15]];
    b = m_regs[w[24:20]];
    // immediate formats straight from the ISA manual
    imm_i = {{20{w[31]}}, w[31:20]};
    imm_s = {{20{w[31]}}, w[31:25], w[11:7]};
    imm_b = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
    imm_j = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
    addr = a + ((op == rv_isa_pkg::op_store) ? imm_s : imm_i);
    idx = int'((addr >> 2) % data_words);
    lane = int'(addr[1:0]);
    exp_pc = m_pc;
    exp_halt = 0;
    exp_wr = 0;
    exp_alu_valid = 0;
    exp_alu = '0;
    val = '0;
    next = m_pc + 4;
    if (w == rv_isa_pkg::inst_ebreak) begin
        // frozen until reset
        exp_halt = 1;
        m_halted = 1;
        next = m_pc;
    end else begin
        case (op)
            rv_isa_pkg::op_lui: begin
                exp_wr = 1;
                val = {w[31:12], 12'h000};
            end
            rv_isa_pkg::op_auipc: begin
                exp_wr = 1;
                exp_alu_valid = 1;
                exp_alu = m_pc + {w[31:12], 12'h000};
                val = exp_alu;
            end
            rv_isa_pkg::op_jal: begin
                exp_wr = 1;
                val = m_pc + 4;
                next = m_pc + imm_j;
            end
            rv_isa_pkg::op_jalr: begin
                if (f3 == 3'b000) begin
                    exp_wr = 1;
                    exp_alu_valid = 1;
                    exp_alu = a + imm_i;
                    val = m_pc + 4;
                    next = exp_alu & ~32'd1;
                end
            end
            rv_isa_pkg::op_imm: begin
                exp_alu_valid = 1;
                exp_wr = (f3 == 3'b000) || (f3 == 3'b011);
                exp_alu = (f3 == 3'b011) ? {31'b0, a < imm_i} : a + imm_i;
                exp_alu_valid = exp_wr;
                val = exp_alu;
            end
            rv_isa_pkg::op_reg: begin
                exp_wr = 1;
                if (f7 == 7'h20 && f3 == 3'b000) exp_alu = a - b;
                else if (f7 != 7'h00) exp_wr = 0;
                else if (f3 == 3'b000) exp_alu = a + b;
                else if (f3 == 3'b011) exp_alu = {31'b0, a < b};
                else if (f3 == 3'b100) exp_alu = a ^ b;
                else if (f3 == 3'b110) exp_alu = a | b;
                else exp_wr = 0;
                exp_alu_valid = exp_wr;
                val = exp_alu;
            end
            rv_isa_pkg::op_load: begin
                exp_wr = (f3 == 3'b010) || (f3 == 3'b100);
                exp_alu_valid = exp_wr;
                exp_alu = addr;
                // lbu zero-extends the selected lane
                val = (f3 == 3'b010) ? m_mem[idx] : {24'b0, m_mem[idx][8*lane +: 8]};
            end
            rv_isa_pkg::op_store: begin
                exp_alu_valid = (f3 == 3'b010) || (f3 == 3'b000);
                exp_alu = addr;
                if (f3 == 3'b010) m_mem[idx] = b;
                else if (f3 == 3'b000) m_mem[idx][8*lane +: 8] = b[7:0];
            end
            rv_isa_pkg::op_branch: begin
                if (f3 == 3'b001) begin
                    exp_alu_valid = 1;
                    exp_alu = {31'b0, a != b};
                    if (a != b) next = m_pc + imm_b;
                end
            end
            default: ;
        endcase
    end
    exp_wb_addr = rd;
    exp_wb_data = val;
    exp_wb_en = exp_wr && (rd != 5'd0);
    if (exp_wb_en) m_regs[rd] = val;
    m_pc = next;
endtask

// random instruction from the supported subset
function automatic rv_isa_pkg::inst_t gen_inst();
    logic [31:0]          r;
    logic [31:0]          v;
    logic [11:0]          off_m;
    logic [20:0]          off_j;
    logic [12:0]          off_b;
    rv_isa_pkg::reg_idx_t rd;
    rv_isa_pkg::reg_idx_t rs1;
    rv_isa_pkg::reg_idx_t rs2;
    rv_isa_pkg::reg_idx_t base;
    rv_isa_pkg::inst_t    w;
    r = $random(seed);
    v = $random(seed);
    // destinations x0..x5, sources x0..x7
    rd = 5'(r[7:0] % 6);
    rs1 = {2'b00, r[10:8]};
    rs2 = {2'b00, r[13:11]};
    // bases stay zero: x0 or the cleared x6/x7
    base = (r[15:14] == 2'd0) ? 5'd0 : ((r[15:14] == 2'd1) ? 5'd6 : 5'd7);
    off_j = 21'((r[18:16] + 1) * 4);
    off_b = 13'((r[21:19] + 1) * 4);
    // offsets with high bits so addresses wrap
    off_m = (r[27:24] == 4'd11 || r[27:24] == 4'd13) ? (v[11:0] & 12'hC3C)
                                                     : (v[11:0] & 12'hC3F);
    case (r[27:24])
        4'd0:  w = {v[31:12], rd, rv_isa_pkg::op_lui};
        4'd1:  w = {v[31:12], rd, rv_isa_pkg::op_auipc};
        4'd2:  w = {off_j[20], off_j[10:1], off_j[11], off_j[19:12], rd, rv_isa_pkg::op_jal};
        4'd3:  w = {4'b0, v[5:0], 2'b00, base, rv_isa_pkg::f3_jalr, rd, rv_isa_pkg::op_jalr};
        4'd4:  w = {v[11:0], rs1, rv_isa_pkg::f3_addi, rd, rv_isa_pkg::op_imm};
        4'd5:  w = {v[11:0], rs1, rv_isa_pkg::f3_sltiu, rd, rv_isa_pkg::op_imm};
        4'd6:  w = {7'h00, rs2, rs1, rv_isa_pkg::f3_add, rd, rv_isa_pkg::op_reg};
        4'd7:  w = {7'h20, rs2, rs1, rv_isa_pkg::f3_add, rd, rv_isa_pkg::op_reg};
        4'd8:  w = {7'h00, rs2, rs1, rv_isa_pkg::f3_xor, rd, rv_isa_pkg::op_reg};
        4'd9:  w = {7'h00, rs2, rs1, rv_isa_pkg::f3_or, rd, rv_isa_pkg::op_reg};
        4'd10: w = {7'h00, rs2, rs1, rv_isa_pkg::f3_sltu, rd, rv_isa_pkg::op_reg};
        4'd11: w = {off_m, base, rv_isa_pkg::f3_lw, rd, rv_isa_pkg::op_load};
        4'd12: w = {off_m, base, rv_isa_pkg::f3_lbu, rd, rv_isa_pkg::op_load};
        4'd13: w = {off_m[11:5], rs2, base, rv_isa_pkg::f3_sw, off_m[4:0], rv_isa_pkg::op_store};
        4'd14: w = {off_m[11:5], rs2, base, rv_isa_pkg::f3_sb, off_m[4:0], rv_isa_pkg::op_store};
        default: w = {off_b[12], off_b[10:5], rs2, rs1, rv_isa_pkg::f3_bne,
                      off_b[4:1], off_b[11], rv_isa_pkg::op_branch};
    endcase
    // rare ebreak
    if (($unsigned($random(seed)) % 200) == 0) w = rv_isa_pkg::inst_ebreak;
    return w;
endfunction

`endif

//--- verif/tb_npc.sv
`timescale 1ns/1ps

module tb_npc;

    localparam int data_words = 256;
    localparam int num_checks = 3000;
    // addi x0, x0, 0
    localparam rv_isa_pkg::inst_t nop_word = 32'h0000_0013;

    logic                 clk;
    logic                 reset;
    rv_isa_pkg::inst_t    inst;
    npc_ctrl_pkg::word_t  dut_pc;
    npc_ctrl_pkg::word_t  dut_alu;
    npc_ctrl_pkg::word_t  dut_wb_data;
    rv_isa_pkg::reg_idx_t dut_wb_addr;
    logic                 dut_wb_en;
    logic                 dut_halt;

    integer               seed;
    rv_isa_pkg::inst_t    prog [256];
    int                   checked;
    int                   halts;
    int                   cycles;

    `include "npc_ref_model.svh"

    npc #(
        .DATA_WORDS (data_words)
    ) UUT (
        .clk        (clk),
        .reset      (reset),
        .inst       (inst),
        .pc         (dut_pc),
        .alu_result (dut_alu),
        .wb_en      (dut_wb_en),
        .wb_addr    (dut_wb_addr),
        .wb_data    (dut_wb_data),
        .halt       (dut_halt)
    );

    initial begin
        clk = 0;
        forever #10 clk = ~clk;
    end

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("Test FAILED");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_word(input string name, input npc_ctrl_pkg::word_t got,
                              input npc_ctrl_pkg::word_t exp);
        if (got !== exp) begin
            report_failure($sformatf("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp));
        end
    endtask

    task automatic check_reg_idx(input string name, input rv_isa_pkg::reg_idx_t got,
                                 input rv_isa_pkg::reg_idx_t exp);
        if (got !== exp) begin
            report_failure($sformatf("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp));
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            report_failure($sformatf("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp));
        end
    endtask

    // drive at the falling edge, compare mid low phase
    task automatic exec_cycle(input rv_isa_pkg::inst_t word);
        inst = word;
        #5;
        model_step(word);
        checked++;
        check_word("pc", dut_pc, exp_pc);
        check_bit("halt", dut_halt, exp_halt);
        check_bit("wb_en", dut_wb_en, exp_wb_en);
        if (exp_wr) begin
            check_reg_idx("wb_addr", dut_wb_addr, exp_wb_addr);
            check_word("wb_data", dut_wb_data, exp_wb_data);
        end
        if (exp_alu_valid) begin
            check_word("alu_result", dut_alu, exp_alu);
        end
    endtask

    task automatic run_cycle(input rv_isa_pkg::inst_t word);
        exec_cycle(word);
        @(negedge clk);
    endtask

    // reset spans two rising edges, released on a falling edge
    task automatic apply_reset();
        reset = 1;
        inst = nop_word;
        repeat (2) @(posedge clk);
        @(negedge clk);
        reset = 0;
        model_reset();
    endtask

    // hold on ebreak, reset, then read every register through addi x0, xN, 0
    task automatic recover_from_halt();
        repeat (3) run_cycle(prog[m_pc[9:2]]);
        halts++;
        apply_reset();
        check_word("pc", dut_pc, npc_ctrl_pkg::reset_pc);
        for (int r = 0; r < 32; r++) begin
            exec_cycle({12'h000, 5'(r), rv_isa_pkg::f3_addi, 5'd0, rv_isa_pkg::op_imm});
            check_word("alu_result", dut_alu, '0);
            @(negedge clk);
        end
    endtask

    function automatic int cycle_limit();
        int h;
        h = (halts < 20) ? halts : 20;
        return num_checks + 10 * h + 50;
    endfunction

    // watchdog
    initial begin
        cycles = 0;
        forever begin
            @(posedge clk);
            cycles++;
            if (cycles > cycle_limit()) begin
                report_failure("Timeout: the run did not finish within the cycle limit");
            end
        end
    end

    initial begin
        seed = 32'ha5258703;
        checked = 0;
        halts = 0;
        reset = 1;
        inst = nop_word;
        // head clears the load/store/jalr bases x6 and x7
        prog[0] = {12'h000, 5'd0, rv_isa_pkg::f3_addi, 5'd6, rv_isa_pkg::op_imm};
        prog[1] = {12'h000, 5'd0, rv_isa_pkg::f3_addi, 5'd7, rv_isa_pkg::op_imm};
        for (int i = 2; i < 256; i++) begin
            prog[i] = gen_inst();
        end
        apply_reset();
        while (checked < num_checks) begin
            run_cycle(prog[m_pc[9:2]]);
            if (m_halted) begin
                recover_from_halt();
            end
        end
        $display("Test OK");
        $finish;
    end

endmodule
